// File: Bender.yml
package:
  name: spi_ram_bridge

sources:
  # Package first, then leaf modules, then the top level
  - logic/spi_ram_pkg.sv
  - logic/spi_byte_engine.sv
  - logic/spi_cs_frame.sv
  - logic/ram_cmd_seq.sv
  - logic/spi_ram_bridge.sv

  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/spi_ram_model.sv
      - test/tb_spi_ram_bridge.sv

// File: all.f
logic/spi_ram_pkg.sv
logic/spi_byte_engine.sv
logic/spi_cs_frame.sv
logic/ram_cmd_seq.sv
logic/spi_ram_bridge.sv
test/tb_clk_gen.sv
test/spi_ram_model.sv
test/tb_spi_ram_bridge.sv

// File: logic/ram_cmd_seq.sv
`timescale 1ns/10ps
`default_nettype none

// One read or write as a four byte SPI frame
module ram_cmd_seq
  #(parameter int BYTE_GAP_CLKS   = 8,
    parameter int DONE_DELAY_CLKS = 32)
  (
    input  wire                      i_Clk,
    input  wire                      i_Rst_L,
    input  wire                      i_wr_req,
    input  wire spi_ram_pkg::addr_t  i_wr_addr,
    input  wire spi_ram_pkg::word_t  i_wr_data,
    input  wire                      i_rd_req,
    input  wire spi_ram_pkg::addr_t  i_rd_addr,
    input  wire                      i_tx_ready,
    input  wire                      i_rx_valid,
    input  wire spi_ram_pkg::byte_t  i_rx_byte,
    output spi_ram_pkg::byte_t       o_tx_byte,
    output logic                     o_tx_valid,
    output logic                     o_busy,
    output logic                     o_done,
    output spi_ram_pkg::word_t       o_rd_data
  );

  localparam int CNT_W    = $clog2(spi_ram_pkg::FRAME_BYTES + 1);
  localparam int WAIT_MAX = (DONE_DELAY_CLKS > BYTE_GAP_CLKS) ? DONE_DELAY_CLKS
                                                              : BYTE_GAP_CLKS;
  localparam int WAIT_W   = (WAIT_MAX > 0) ? $clog2(WAIT_MAX + 1) : 1;

  spi_ram_pkg::seq_state_e r_state;
  logic [CNT_W-1:0]        r_byte_cnt;   // Bytes handed off so far
  logic [WAIT_W-1:0]       r_wait_cnt;   // Ready cycles seen in GAP
  logic                    r_rx_seen;    // Command echo byte already skipped

  spi_ram_pkg::op_e        r_op;
  spi_ram_pkg::addr_t      r_addr;
  spi_ram_pkg::word_t      r_wr_word;    // Shifts left one byte per send
  spi_ram_pkg::word_t      r_rd_word;    // Assembled MISO bytes

  logic w_accept;
  logic w_last;       // All four bytes handed off
  logic w_wait_hit;
  logic w_emit_cmd;
  logic w_emit_data;

  assign w_accept    = (r_state == spi_ram_pkg::IDLE) & (i_wr_req | i_rd_req);
  assign w_last      = (r_byte_cnt == CNT_W'(spi_ram_pkg::FRAME_BYTES));
  assign w_wait_hit  = w_last ? (r_wait_cnt == WAIT_W'(DONE_DELAY_CLKS))
                              : (r_wait_cnt == WAIT_W'(BYTE_GAP_CLKS));
  assign w_emit_cmd  = (r_state == spi_ram_pkg::LOAD) & i_tx_ready;
  assign w_emit_data = (r_state == spi_ram_pkg::GAP) & i_tx_ready & w_wait_hit & ~w_last;

  ////////////////////
  // Control FSM

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      r_state    <= spi_ram_pkg::IDLE;
      r_byte_cnt <= '0;
      r_wait_cnt <= '0;
      r_rx_seen  <= 1'b0;
      o_tx_valid <= 1'b0;
      o_busy     <= 1'b0;
      o_done     <= 1'b0;
      o_rd_data  <= '0;
    end
    else
    begin
      o_tx_valid <= 1'b0;  // Single cycle pulses
      o_done     <= 1'b0;

      if (i_rx_valid)
        r_rx_seen <= 1'b1;

      case (r_state)
        spi_ram_pkg::IDLE:
        begin
          if (w_accept)
          begin
            o_busy     <= 1'b1;
            r_byte_cnt <= '0;
            r_wait_cnt <= '0;
            r_rx_seen  <= 1'b0;
            r_state    <= spi_ram_pkg::LOAD;
          end
        end
        spi_ram_pkg::LOAD:
        begin
          if (w_emit_cmd)
          begin
            o_tx_valid <= 1'b1;                 // Command byte, opens the frame
            r_state    <= spi_ram_pkg::SEND;
          end
        end
        spi_ram_pkg::SEND:
        begin
          r_byte_cnt <= r_byte_cnt + 1'b1;
          r_state    <= spi_ram_pkg::GAP;
        end
        spi_ram_pkg::GAP:
        begin
          if (i_tx_ready)  // Only ready cycles count
          begin
            if (!w_wait_hit)
              r_wait_cnt <= r_wait_cnt + 1'b1;
            else if (w_last)
            begin
              r_wait_cnt <= '0;
              o_done     <= 1'b1;
              if (r_op == spi_ram_pkg::OP_READ)
                o_rd_data <= r_rd_word;
              r_state    <= spi_ram_pkg::SETTLE;
            end
            else
            begin
              r_wait_cnt <= '0;
              o_tx_valid <= 1'b1;
              r_state    <= spi_ram_pkg::SEND;
            end
          end
        end
        spi_ram_pkg::SETTLE:
        begin
          o_busy  <= 1'b0;  // Accept again next cycle
          r_state <= spi_ram_pkg::IDLE;
        end
        default: r_state <= spi_ram_pkg::IDLE;
      endcase
    end
  end

  ////////////////////
  // Request payload and byte data

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      r_op      <= spi_ram_pkg::OP_WRITE;
      r_addr    <= '0;
      r_wr_word <= '0;
      o_tx_byte <= '0;
      r_rd_word <= '0;
    end
    else
    begin
      if (w_accept)
      begin
        // Write wins when both arrive together
        r_op      <= i_wr_req ? spi_ram_pkg::OP_WRITE : spi_ram_pkg::OP_READ;
        r_addr    <= i_wr_req ? i_wr_addr : i_rd_addr;
        r_wr_word <= i_wr_data;
      end
      else if (w_emit_data)
        r_wr_word <= r_wr_word << spi_ram_pkg::BYTE_W;  // MSB first

      if (w_emit_cmd)
        o_tx_byte <= {r_op, r_addr};  // Opcode above address
      else if (w_emit_data)
        o_tx_byte <= (r_op == spi_ram_pkg::OP_WRITE)
                     ? r_wr_word[spi_ram_pkg::DATA_W-1 -: spi_ram_pkg::BYTE_W]
                     : '0;            // Dummy byte on a read

      if (i_rx_valid && r_rx_seen && (r_op == spi_ram_pkg::OP_READ))
        r_rd_word <= {r_rd_word[spi_ram_pkg::DATA_W-spi_ram_pkg::BYTE_W-1:0], i_rx_byte};
    end
  end

endmodule

`default_nettype wire

// File: logic/spi_byte_engine.sv
`timescale 1ns/10ps
`default_nettype none

// Shifts one byte each way per tx_valid, any SPI mode
module spi_byte_engine
  #(parameter int SPI_MODE          = 0,
    parameter int CLKS_PER_HALF_BIT = 2)
  (
    input  wire                      i_Clk,
    input  wire                      i_Rst_L,
    input  wire spi_ram_pkg::byte_t  i_tx_byte,
    input  wire                      i_tx_valid,
    input  wire                      i_spi_miso,
    output logic                     o_ready,
    output logic                     o_rx_valid,
    output spi_ram_pkg::byte_t       o_rx_byte,
    output logic                     o_spi_clk,
    output logic                     o_spi_mosi
  );

  // Mode decode
  localparam logic CPOL = (SPI_MODE == 2) || (SPI_MODE == 3);  // Idle level of SCLK
  localparam logic CPHA = (SPI_MODE == 1) || (SPI_MODE == 3);  // Sample on trailing edge

  localparam int EDGES  = 2 * spi_ram_pkg::BYTE_W;             // 16 SCLK edges per byte
  localparam int EDGE_W = $clog2(EDGES + 1);
  localparam int HALF_W = $clog2(CLKS_PER_HALF_BIT * 2);
  localparam int BIT_W  = $clog2(spi_ram_pkg::BYTE_W);

  logic [HALF_W-1:0]  r_half_cnt;  // Position inside one SCLK period
  logic [EDGE_W-1:0]  r_edges;     // Edges left in this byte
  logic               r_sclk;
  logic               r_lead;      // One cycle flags per edge
  logic               r_trail;
  logic               r_tx_dv;
  spi_ram_pkg::byte_t r_tx_byte;
  logic [BIT_W-1:0]   r_tx_bit;
  logic [BIT_W-1:0]   r_rx_bit;

  ////////////////////
  // SCLK edge generation

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      o_ready    <= 1'b0;
      r_edges    <= '0;
      r_lead     <= 1'b0;
      r_trail    <= 1'b0;
      r_sclk     <= CPOL;
      r_half_cnt <= '0;
    end
    else
    begin
      r_lead  <= 1'b0;
      r_trail <= 1'b0;

      if (i_tx_valid)
      begin
        o_ready <= 1'b0;
        r_edges <= EDGE_W'(EDGES);
      end
      else if (r_edges != '0)
      begin
        o_ready <= 1'b0;
        if (r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT * 2 - 1))
        begin
          r_edges    <= r_edges - 1'b1;
          r_trail    <= 1'b1;
          r_half_cnt <= '0;
          r_sclk     <= ~r_sclk;
        end
        else if (r_half_cnt == HALF_W'(CLKS_PER_HALF_BIT - 1))
        begin
          r_edges    <= r_edges - 1'b1;
          r_lead     <= 1'b1;
          r_half_cnt <= r_half_cnt + 1'b1;
          r_sclk     <= ~r_sclk;
        end
        else
          r_half_cnt <= r_half_cnt + 1'b1;
      end
      else
        o_ready <= 1'b1;  // All edges done
    end
  end

  // Local copy so the sequencer may change its byte
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
      r_tx_byte <= '0;
    else if (i_tx_valid)
      r_tx_byte <= i_tx_byte;
  end

  ////////////////////
  // MOSI, MSB first

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      r_tx_dv    <= 1'b0;
      o_spi_mosi <= 1'b0;
      r_tx_bit   <= BIT_W'(spi_ram_pkg::BYTE_W - 1);
    end
    else
    begin
      r_tx_dv <= i_tx_valid;  // Byte is registered one cycle later
      if (o_ready)
        r_tx_bit <= BIT_W'(spi_ram_pkg::BYTE_W - 1);
      else if (r_tx_dv & ~CPHA)
      begin
        // CPHA 0 needs the first bit out before the leading edge
        o_spi_mosi <= r_tx_byte[spi_ram_pkg::BYTE_W-1];
        r_tx_bit   <= BIT_W'(spi_ram_pkg::BYTE_W - 2);
      end
      else if ((r_lead & CPHA) | (r_trail & ~CPHA))
      begin
        o_spi_mosi <= r_tx_byte[r_tx_bit];
        r_tx_bit   <= r_tx_bit - 1'b1;
      end
    end
  end

  ////////////////////
  // MISO sampling

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      o_rx_byte  <= '0;
      o_rx_valid <= 1'b0;
      r_rx_bit   <= BIT_W'(spi_ram_pkg::BYTE_W - 1);
    end
    else
    begin
      o_rx_valid <= 1'b0;
      if (o_ready)
        r_rx_bit <= BIT_W'(spi_ram_pkg::BYTE_W - 1);
      else if ((r_lead & ~CPHA) | (r_trail & CPHA))
      begin
        o_rx_byte[r_rx_bit] <= i_spi_miso;
        r_rx_bit            <= r_rx_bit - 1'b1;
        if (r_rx_bit == '0)
          o_rx_valid <= 1'b1;  // Eighth bit in
      end
    end
  end

  // One cycle delay lines SCLK up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
      o_spi_clk <= CPOL;
    else
      o_spi_clk <= r_sclk;
  end

endmodule

`default_nettype wire

// File: logic/spi_cs_frame.sv
`timescale 1ns/10ps
`default_nettype none

// Holds CS low over one four byte frame
module spi_cs_frame
  #(parameter int CS_INACTIVE_CLKS = 1)
  (
    input  wire   i_Clk,
    input  wire   i_Rst_L,
    input  wire   i_tx_valid,
    input  wire   i_engine_ready,
    output logic  o_tx_ready,
    output logic  o_spi_cs_n
  );

  localparam int CNT_W = $clog2(spi_ram_pkg::FRAME_BYTES + 1);
  localparam int INACT_W = (CS_INACTIVE_CLKS > 0) ? $clog2(CS_INACTIVE_CLKS + 1) : 1;

  spi_ram_pkg::cs_state_e r_state;
  logic [CNT_W-1:0]       r_bytes_left;    // Still to be started in this frame
  logic [INACT_W-1:0]     r_inactive_cnt;

  ////////////////////
  // Chip-select FSM

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (~i_Rst_L)
    begin
      r_state        <= spi_ram_pkg::CS_IDLE;
      o_spi_cs_n     <= 1'b1;  // Deselected
      r_bytes_left   <= '0;
      r_inactive_cnt <= '0;
    end
    else
    begin
      case (r_state)
        spi_ram_pkg::CS_IDLE:
        begin
          if (i_tx_valid)  // First byte opens the frame
          begin
            r_bytes_left <= CNT_W'(spi_ram_pkg::FRAME_BYTES - 1);
            o_spi_cs_n   <= 1'b0;
            r_state      <= spi_ram_pkg::CS_TRANSFER;
          end
        end
        spi_ram_pkg::CS_TRANSFER:
        begin
          if (i_engine_ready)
          begin
            if (r_bytes_left != '0)
            begin
              if (i_tx_valid)
                r_bytes_left <= r_bytes_left - 1'b1;
            end
            else
            begin
              // Last byte shifted out, close the frame
              o_spi_cs_n     <= 1'b1;
              r_inactive_cnt <= INACT_W'(CS_INACTIVE_CLKS);
              r_state        <= spi_ram_pkg::CS_INACTIVE;
            end
          end
        end
        spi_ram_pkg::CS_INACTIVE:
        begin
          if (r_inactive_cnt != '0)
            r_inactive_cnt <= r_inactive_cnt - 1'b1;
          else
            r_state <= spi_ram_pkg::CS_IDLE;  // CS_INACTIVE_CLKS+1 cycles high
        end
        default:
        begin
          o_spi_cs_n <= 1'b1;
          r_state    <= spi_ram_pkg::CS_IDLE;
        end
      endcase
    end
  end

  // Ready drops in the same cycle as a valid
  assign o_tx_ready = ((r_state == spi_ram_pkg::CS_IDLE) |
                       ((r_state == spi_ram_pkg::CS_TRANSFER) & i_engine_ready &
                        (r_bytes_left != '0))) & ~i_tx_valid;

endmodule

`default_nettype wire

// File: logic/spi_ram_bridge.sv
`timescale 1ns/10ps
`default_nettype none

// Parallel request port to 24-bit word SPI memory
module spi_ram_bridge
  #(parameter int SPI_MODE          = 0,   // 0..3
    parameter int CLKS_PER_HALF_BIT = 2,   // At least 2
    parameter int CS_INACTIVE_CLKS  = 1,
    parameter int BYTE_GAP_CLKS     = 8,
    parameter int DONE_DELAY_CLKS   = 32)
  (
    input  wire                      i_Clk,
    input  wire                      i_Rst_L,
    // Request side
    input  wire                      i_wr_req,
    input  wire spi_ram_pkg::addr_t  i_wr_addr,
    input  wire spi_ram_pkg::word_t  i_wr_data,
    input  wire                      i_rd_req,
    input  wire spi_ram_pkg::addr_t  i_rd_addr,
    output wire                      o_busy,
    output wire                      o_done,
    output wire spi_ram_pkg::word_t  o_rd_data,
    // SPI pins
    output wire                      o_spi_clk,
    output wire                      o_spi_mosi,
    input  wire                      i_spi_miso,
    output wire                      o_spi_cs_n
  );

  wire spi_ram_pkg::byte_t w_tx_byte;   // Sequencer to engine
  wire                     w_tx_valid;
  wire                     w_tx_ready;  // Gated by the CS framer
  wire                     w_engine_ready;
  wire                     w_rx_valid;
  wire spi_ram_pkg::byte_t w_rx_byte;

  ram_cmd_seq
    #(.BYTE_GAP_CLKS   (BYTE_GAP_CLKS),
      .DONE_DELAY_CLKS (DONE_DELAY_CLKS))
  u_seq
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_wr_req   (i_wr_req),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),
    .i_rd_req   (i_rd_req),
    .i_rd_addr  (i_rd_addr),
    .i_tx_ready (w_tx_ready),
    .i_rx_valid (w_rx_valid),
    .i_rx_byte  (w_rx_byte),
    .o_tx_byte  (w_tx_byte),
    .o_tx_valid (w_tx_valid),
    .o_busy     (o_busy),
    .o_done     (o_done),
    .o_rd_data  (o_rd_data)
  );

  spi_cs_frame
    #(.CS_INACTIVE_CLKS (CS_INACTIVE_CLKS))
  u_cs
  (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_tx_valid     (w_tx_valid),
    .i_engine_ready (w_engine_ready),
    .o_tx_ready     (w_tx_ready),
    .o_spi_cs_n     (o_spi_cs_n)
  );

  spi_byte_engine
    #(.SPI_MODE          (SPI_MODE),
      .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT))
  u_engine
  (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_byte  (w_tx_byte),
    .i_tx_valid (w_tx_valid),
    .i_spi_miso (i_spi_miso),
    .o_ready    (w_engine_ready),
    .o_rx_valid (w_rx_valid),
    .o_rx_byte  (w_rx_byte),
    .o_spi_clk  (o_spi_clk),
    .o_spi_mosi (o_spi_mosi)
  );

endmodule

`default_nettype wire

// File: logic/spi_ram_pkg.sv
`default_nettype none

package spi_ram_pkg;

  ////////////////////
  // Widths

  localparam int ADDR_W      = 7;   // Word address bits
  localparam int DATA_W      = 24;  // Memory word
  localparam int BYTE_W      = 8;   // One SPI byte
  localparam int FRAME_BYTES = 4;   // Command byte plus three data bytes

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;
  typedef logic [BYTE_W-1:0] byte_t;

  ////////////////////
  // Opcode carried in bit 7 of the command byte

  typedef enum logic
  {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } op_e;

  // Request sequencer
  typedef enum logic [2:0]
  {
    IDLE,    // Waiting for a request
    LOAD,    // Command byte pending
    GAP,     // Counting ready cycles before next byte or done
    SEND,    // Byte handed to the engine
    SETTLE   // Done pulse, result visible
  } seq_state_e;

  // Chip-select framing
  typedef enum logic [1:0]
  {
    CS_IDLE,
    CS_TRANSFER,
    CS_INACTIVE
  } cs_state_e;

endpackage

`default_nettype wire

// File: test/spi_ram_model.sv
`timescale 1ns/10ps
`default_nettype none

// SPI slave memory, mode 0, one command byte and three data bytes per frame
module spi_ram_model
  (
    input  wire  i_spi_clk,
    input  wire  i_spi_mosi,
    input  wire  i_spi_cs_n,
    output logic o_spi_miso
  );

  localparam int DEPTH = 2 ** spi_ram_pkg::ADDR_W;

  spi_ram_pkg::word_t mem [0:DEPTH-1];
  logic [5:0]         r_bit_cnt;     // Bits received in this frame
  logic [31:0]        r_shift_in;
  spi_ram_pkg::op_e   r_op;
  spi_ram_pkg::addr_t r_addr;
  spi_ram_pkg::word_t r_out_word;    // Word being returned on a read

  // Every word starts as its address in all three bytes
  initial
  begin
    o_spi_miso = 1'b0;
    r_bit_cnt  = '0;
    r_shift_in = '0;
    r_op       = spi_ram_pkg::OP_WRITE;
    for (int a = 0; a < DEPTH; a++)
      mem[a] = {3{spi_ram_pkg::byte_t'(a)}};
  end

  always @(negedge i_spi_cs_n)
  begin
    r_bit_cnt  = '0;     // New frame
    o_spi_miso <= 1'b0;
  end

  // Slave samples MOSI on the rising edge
  always @(posedge i_spi_clk)
  begin
    if (!i_spi_cs_n)
    begin
      r_shift_in = {r_shift_in[30:0], i_spi_mosi};
      r_bit_cnt  = r_bit_cnt + 1'b1;
      if (r_bit_cnt == 6'd8)
      begin
        r_op       = spi_ram_pkg::op_e'(r_shift_in[7]);  // Opcode above address
        r_addr     = r_shift_in[6:0];
        r_out_word = mem[r_addr];
      end
      if ((r_bit_cnt == 6'd32) && (r_op == spi_ram_pkg::OP_WRITE))
        mem[r_addr] = r_shift_in[23:0];
    end
  end

  // Next read bit goes out on the falling edge
  always @(negedge i_spi_clk)
  begin
    int idx;
    idx = 31 - int'(r_bit_cnt);
    if (!i_spi_cs_n && (r_bit_cnt >= 6'd8) && (r_bit_cnt < 6'd32) &&
        (r_op == spi_ram_pkg::OP_READ))
      o_spi_miso <= r_out_word[idx];
  end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

// Free running clock and a power-on reset for the testbench
module tb_clk_gen
  #(parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2)
  (
    output logic o_clk,
    output logic o_rst_l
  );

  initial
  begin
    o_clk = 1'b0;
    forever
      #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // Reset held low over the first edges, released just after one
  initial
  begin
    o_rst_l = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst_l = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_spi_ram_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_ram_bridge;

  localparam int NUM_TXN    = 40;    // Transactions budgeted for the run
  localparam int TXN_CYCLES = 400;   // Generous bound for one frame plus delays
  localparam int MAX_CYCLES = NUM_TXN * TXN_CYCLES;
  localparam int DEPTH      = 2 ** spi_ram_pkg::ADDR_W;

  wire                clk;
  wire                rst_l;
  logic               wr_req;
  spi_ram_pkg::addr_t wr_addr;
  spi_ram_pkg::word_t wr_data;
  logic               rd_req;
  spi_ram_pkg::addr_t rd_addr;
  wire                busy;
  wire                done;
  spi_ram_pkg::word_t rd_data;
  wire                spi_clk;
  wire                spi_mosi;
  wire                spi_miso;
  wire                spi_cs_n;

  spi_ram_pkg::word_t shadow [0:DEPTH-1];  // Expected memory contents
  logic [15:0]        lfsr = 16'd55161;
  int err_cnt = 0;
  int check_cnt = 0;
  int txn_cnt = 0;
  int frame_err_cnt = 0;
  int cycle_cnt = 0;
  int done_cnt = 0;        // Monitor counters, never cleared
  int cs_fall_cnt = 0;
  int cs_rise_cnt = 0;
  int sclk_rise_cnt = 0;
  int base_done;
  int base_fall;
  int base_rise;
  int base_sclk;
  logic prev_cs_n = 1'b1;
  logic prev_sclk = 1'b0;
  logic exp_is_read = 1'b0;
  spi_ram_pkg::word_t exp_word = '0;

  tb_clk_gen #(.PERIOD_NS (100), .RST_CYCLES (2)) u_clk (.o_clk (clk), .o_rst_l (rst_l));

  spi_ram_bridge
    #(.SPI_MODE          (0),
      .CLKS_PER_HALF_BIT (2),
      .CS_INACTIVE_CLKS  (1))
  i_dut
  (
    .i_Clk      (clk),
    .i_Rst_L    (rst_l),
    .i_wr_req   (wr_req),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_rd_req   (rd_req),
    .i_rd_addr  (rd_addr),
    .o_busy     (busy),
    .o_done     (done),
    .o_rd_data  (rd_data),
    .o_spi_clk  (spi_clk),
    .o_spi_mosi (spi_mosi),
    .i_spi_miso (spi_miso),
    .o_spi_cs_n (spi_cs_n)
  );

  spi_ram_model u_mem (.i_spi_clk (spi_clk), .i_spi_mosi (spi_mosi),
                       .i_spi_cs_n (spi_cs_n), .o_spi_miso (spi_miso));

  ////////////////////
  // Random values and reference model

  // Taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  function automatic spi_ram_pkg::word_t expected_read(input spi_ram_pkg::addr_t a);
    return shadow[a];
  endfunction

  function automatic void shadow_write(input spi_ram_pkg::addr_t a,
                                       input spi_ram_pkg::word_t d);
    shadow[a] = d;
  endfunction

  ////////////////////
  // Compare tasks

  task automatic check_word(input string name, input spi_ram_pkg::word_t got,
                            input spi_ram_pkg::word_t exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    check_cnt++;
    if (got != exp)
    begin
      err_cnt++;
      frame_err_cnt++;
      $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // Monitor, read checker and timeout

  always @(posedge clk)
  begin
    if (rst_l)
    begin
      if (done)
        done_cnt <= done_cnt + 1;
      if (prev_cs_n && !spi_cs_n)
        cs_fall_cnt <= cs_fall_cnt + 1;
      if (!prev_cs_n && spi_cs_n)
        cs_rise_cnt <= cs_rise_cnt + 1;
      if (!prev_sclk && spi_clk)
        sclk_rise_cnt <= sclk_rise_cnt + 1;
    end
    prev_cs_n <= spi_cs_n;
    prev_sclk <= spi_clk;
  end

  // Read word is valid in the done cycle
  always @(posedge clk)
  begin
    if ((done === 1'b1) && exp_is_read)
      check_word("o_rd_data", rd_data, exp_word);
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Run stopped after %0d cycles because a transaction never finished",
               cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////
  // Stimulus

  task automatic wait_cycle();
    @(posedge clk);
    #1;  // Drive just after the edge
  endtask

  task automatic start_txn(input spi_ram_pkg::op_e op, input spi_ram_pkg::addr_t a,
                           input spi_ram_pkg::word_t d);
    while (busy)
      wait_cycle();
    base_done   = done_cnt;
    base_fall   = cs_fall_cnt;
    base_rise   = cs_rise_cnt;
    base_sclk   = sclk_rise_cnt;
    exp_is_read = (op == spi_ram_pkg::OP_READ);
    exp_word    = expected_read(a);
    if (op == spi_ram_pkg::OP_WRITE)
    begin
      wr_req  = 1'b1;
      wr_addr = a;
      wr_data = d;
      shadow_write(a, d);
    end
    else
    begin
      rd_req  = 1'b1;
      rd_addr = a;
    end
    wait_cycle();
    wr_req = 1'b0;  // One cycle pulse
    rd_req = 1'b0;
  endtask

  // Waits for done, then checks the frame shape
  task automatic finish_txn();
    while (done_cnt == base_done)
      wait_cycle();
    txn_cnt++;
    check_count("cs_n falls", cs_fall_cnt - base_fall, 1);
    check_count("cs_n rises", cs_rise_cnt - base_rise, 1);
    check_count("o_spi_clk rises", sclk_rise_cnt - base_sclk, 32);
    check_bit("o_done", done, 1'b0);  // Pulse lasts a single cycle
  endtask

  task automatic run_txn(input spi_ram_pkg::op_e op, input spi_ram_pkg::addr_t a,
                         input spi_ram_pkg::word_t d);
    start_txn(op, a, d);
    finish_txn();
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    if (errs == 0)
      $display("test %0d %s ... ok", num, name);
    else
      $display("test %0d %s ... %0d errors", num, name, errs);
  endtask

  initial
  begin
    int                 start_err;
    logic [31:0]        v;
    spi_ram_pkg::addr_t a;
    spi_ram_pkg::addr_t b;
    spi_ram_pkg::word_t d;

    wr_req  = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_req  = 1'b0;
    rd_addr = '0;
    for (int i = 0; i < DEPTH; i++)
      shadow[i] = {3{spi_ram_pkg::byte_t'(i)}};  // Address in every byte
    wait (rst_l === 1'b1);
    wait_cycle();

    // 1 Reset state
    start_err = err_cnt;
    check_bit("o_busy", busy, 1'b0);
    check_bit("o_done", done, 1'b0);
    check_bit("o_spi_cs_n", spi_cs_n, 1'b1);
    check_bit("o_spi_clk", spi_clk, 1'b0);
    check_bit("o_spi_mosi", spi_mosi, 1'b0);
    check_word("o_rd_data", rd_data, '0);
    report_test(1, "reset state", err_cnt - start_err);

    // 2 Untouched word
    start_err = err_cnt;
    draw_bits(spi_ram_pkg::ADDR_W, v);
    a = spi_ram_pkg::addr_t'(v);
    run_txn(spi_ram_pkg::OP_READ, a, '0);
    report_test(2, "read before write", err_cnt - start_err);

    // 3 Random write and read back pairs
    start_err = err_cnt;
    repeat (20)
    begin
      draw_bits(spi_ram_pkg::ADDR_W, v);
      a = spi_ram_pkg::addr_t'(v);
      draw_bits(spi_ram_pkg::DATA_W, v);
      d = spi_ram_pkg::word_t'(v);
      run_txn(spi_ram_pkg::OP_WRITE, a, d);
      run_txn(spi_ram_pkg::OP_READ, a, '0);
    end
    report_test(3, "write then read back", err_cnt - start_err);

    // 5 Write pulsed during a read must vanish
    start_err = err_cnt;
    draw_bits(spi_ram_pkg::ADDR_W, v);
    a = spi_ram_pkg::addr_t'(v);
    draw_bits(spi_ram_pkg::ADDR_W, v);
    b = spi_ram_pkg::addr_t'(v);
    start_txn(spi_ram_pkg::OP_READ, a, '0);
    repeat (3) wait_cycle();
    check_bit("o_busy", busy, 1'b1);
    wr_req  = 1'b1;
    wr_addr = b;
    wr_data = ~expected_read(b);  // Differs from the stored word
    wait_cycle();
    wr_req = 1'b0;
    finish_txn();
    repeat (300) wait_cycle();
    check_count("o_done pulses", done_cnt - base_done, 1);
    check_count("cs_n falls", cs_fall_cnt - base_fall, 1);
    run_txn(spi_ram_pkg::OP_READ, b, '0);
    report_test(5, "busy rejection", err_cnt - start_err);

    report_test(4, "one frame per transaction", frame_err_cnt);

    $display("Tests 5, transactions %0d, checks %0d, errors %0d",
             txn_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
